/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module tb_rv3_core -Mdir obj_dir
	./obj_dir/Vtb_rv3_core | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// program length: 15 seed words, body, marker store, jump to self
localparam int PROG_LEN = 61;
localparam int MARK_IDX = PROG_LEN - 2;
localparam logic [31:0] MARKER_ADR = 32'h0000_0200;

logic [31:0] prog [0:1023];
// reference data memory, word indexed
logic [31:0] mdl_mem [0:1023];
// expected bus accesses in program order
logic [31:0] exp_adr[$];
logic        exp_we[$];
logic [31:0] exp_wdata[$];

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, OPC_LUI};
endfunction

// fill pattern, every address bit matters
function automatic logic [31:0] init_word(logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

// architectural alu, straight from the isa text
function automatic logic [31:0] isa_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  r = (a < b) ? 32'd1 : 32'd0;
        3'b100:  r = a ^ b;
        3'b101:  r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic isa_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    logic t;
    case (f3)
        3'b000:  t = (a == b);
        3'b001:  t = (a != b);
        3'b100:  t = ($signed(a) < $signed(b));
        3'b101:  t = ($signed(a) >= $signed(b));
        3'b110:  t = (a < b);
        default: t = (a >= b);
    endcase
    return t;
endfunction

// random forward-only program in prog
task build_program;
    int          kind;
    int          k;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [4:0]  rd;
    for (int i = 0; i < 1024; i++) begin
        prog[i] = NOP_INSTR;
    end
    // seed x1..x7, x8 is the data window base and never written again
    for (int r = 1; r < 8; r++) begin
        prog[2*r-2] = enc_u(20'($urandom), 5'(r));
        prog[2*r-1] = enc_i(12'($urandom), 5'(r), F3_ADD, 5'(r), OPC_OP_IMM);
    end
    prog[14] = enc_i(12'h100, 5'd0, F3_ADD, 5'd8, OPC_OP_IMM);
    for (int i = 15; i < MARK_IDX; i++) begin
        kind = $urandom_range(0, 9);
        rd   = 5'($urandom_range(1, 7));
        f3   = 3'($urandom_range(0, 7));
        k    = $urandom_range(2, 3);
        if (i + k > MARK_IDX) begin
            k = MARK_IDX - i;
        end
        if (kind <= 2) begin
            f7 = ((f3 == F3_ADD || f3 == F3_SR) && $urandom_range(0, 1) == 1) ? F7_ALT : 7'd0;
            prog[i] = enc_r(f7, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), f3, rd);
        end else if (kind <= 4) begin
            imm = 12'($urandom);
            if (f3 == F3_SLL) begin
                imm[11:5] = 7'd0;
            end else if (f3 == F3_SR) begin
                imm[11:5] = ($urandom_range(0, 1) == 1) ? F7_ALT : 7'd0;
            end
            prog[i] = enc_i(imm, 5'($urandom_range(0, 7)), f3, rd, OPC_OP_IMM);
        end else if (kind == 5) begin
            prog[i] = enc_u(20'($urandom), rd);
        end else if (kind == 6) begin
            prog[i] = enc_i(12'(4 * $urandom_range(0, 7)), 5'd8, 3'b010, rd, OPC_LOAD);
        end else if (kind == 7) begin
            prog[i] = enc_s(12'(4 * $urandom_range(0, 7)), 5'($urandom_range(0, 7)), 5'd8);
        end else if (kind == 8) begin
            k  = $urandom_range(0, 5);
            // skip the two unused funct3 codes
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            k  = (i + 3 > MARK_IDX) ? MARK_IDX - i : $urandom_range(2, 3);
            prog[i] = enc_b(13'(4 * k), 5'($urandom_range(1, 7)),
                            5'($urandom_range(1, 7)), f3);
        end else begin
            prog[i] = enc_j(21'(4 * k), rd);
        end
    end
    prog[MARK_IDX]     = enc_s(12'h200, 5'd1, 5'd0);
    prog[MARK_IDX + 1] = enc_j(21'd0, 5'd0);
endtask

// runs prog at isa level, fills exp_* and mdl_mem
task run_model;
    logic [31:0] xr [0:31];
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        xr[i] = 32'd0;
    end
    pc    = 32'd0;
    steps = 0;
    while (steps < 4000) begin
        ins = prog[pc[11:2]];
        // jump to self ends the program
        if (ins == enc_j(21'd0, 5'd0)) begin
            break;
        end
        a   = xr[ins[19:15]];
        b   = xr[ins[24:20]];
        nxt = pc + 32'd4;
        wr  = 1'b1;
        res = 32'd0;
        case (ins[6:0])
            OPC_OP:     res = isa_alu(ins[14:12], ins[30], a, b);
            OPC_OP_IMM: res = isa_alu(ins[14:12], (ins[14:12] == F3_SR) && ins[30], a,
                                      {{20{ins[31]}}, ins[31:20]});
            OPC_LUI:    res = {ins[31:12], 12'd0};
            OPC_LOAD: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                res  = mdl_mem[addr[11:2]];
                exp_adr.push_back(addr);
                exp_we.push_back(1'b0);
                exp_wdata.push_back(32'd0);
            end
            OPC_STORE: begin
                wr   = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mdl_mem[addr[11:2]] = b;
                exp_adr.push_back(addr);
                exp_we.push_back(1'b1);
                exp_wdata.push_back(b);
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if (isa_taken(ins[14:12], a, b)) begin
                    nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                res = pc + 32'd4;
                nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            xr[ins[11:7]] = res;
        end
        pc = nxt;
        steps++;
    end
endtask

`endif

/* sim/tb_rv3_core.sv */
`timescale 1ns/1ps

module tb_rv3_core;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    `include "isa_model.svh"

    logic       clk;
    logic       rst_n;
    imem_addr_t imem_addr;
    word_t      imem_data;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_wdata;
    word_t      wb_rdata;
    logic       wb_ack;

    // slave side data array
    word_t      dmem [0:1023];
    int         reset_errs;
    int         seq_errs;
    int         stall_errs;
    int         mem_errs;
    int         acc_count;
    bit         marker_seen;
    int         cycles;
    int         total;

    rv3_core u_rv3_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory samples the address before the edge and drives the word after it
    initial begin
        imem_addr_t addr_q;
        forever begin
            @(negedge clk);
            addr_q = imem_addr;
            @(posedge clk);
            #1;
            imem_data = prog[addr_q];
        end
    end

    // compare one acked access against the model list, then apply it
    task automatic check_access(input word_t adr, input logic we, input word_t wdata);
        if (acc_count >= exp_adr.size()) begin
            seq_errs++;
            $display("extra bus access at address %h beyond the expected list", adr);
        end else begin
            if (adr !== exp_adr[acc_count]) begin
                seq_errs++;
                $display("MISMATCH wb_adr access %0d: got %h expected %h",
                         acc_count, adr, exp_adr[acc_count]);
            end
            if (we !== exp_we[acc_count]) begin
                seq_errs++;
                $display("MISMATCH wb_we access %0d: got %h expected %h",
                         acc_count, we, exp_we[acc_count]);
            end else if (we && wdata !== exp_wdata[acc_count]) begin
                seq_errs++;
                $display("MISMATCH wb_wdata access %0d: got %h expected %h",
                         acc_count, wdata, exp_wdata[acc_count]);
            end
        end
        if (we) begin
            dmem[adr[11:2]] = wdata;
        end
        if (we && adr == MARKER_ADR) begin
            marker_seen = 1'b1;
        end
        acc_count++;
    endtask

    // wishbone classic slave with 1 to 4 wait cycles per access
    initial begin
        logic  active;
        logic  next_ack;
        int    wait_left;
        word_t hold_adr;
        logic  hold_we;
        word_t hold_wdata;
        active = 1'b0;
        forever begin
            @(negedge clk);
            next_ack = 1'b0;
            if (rst_n !== 1'b1 || wb_ack) begin
                // master drops the request on this edge
                active = 1'b0;
            end else if (wb_stb === 1'b1) begin
                if (wb_cyc !== 1'b1) begin
                    stall_errs++;
                    $display("wb_stb high without wb_cyc");
                end
                if (!active) begin
                    active     = 1'b1;
                    wait_left  = $urandom_range(1, 4);
                    hold_adr   = wb_adr;
                    hold_we    = wb_we;
                    hold_wdata = wb_wdata;
                end else if (wb_adr !== hold_adr || wb_we !== hold_we ||
                             wb_wdata !== hold_wdata) begin
                    stall_errs++;
                    $display("MISMATCH wb_adr wb_we wb_wdata: got %h %h %h held %h %h %h",
                             wb_adr, wb_we, wb_wdata, hold_adr, hold_we, hold_wdata);
                end
                wait_left--;
                if (wait_left == 0) begin
                    next_ack = 1'b1;
                    active   = 1'b0;
                    check_access(hold_adr, hold_we, hold_wdata);
                end
            end
            @(posedge clk);
            #1;
            wb_ack = next_ack;
            // junk on rdata outside the ack cycle
            wb_rdata = (next_ack && !hold_we) ? dmem[hold_adr[11:2]] : $urandom;
        end
    end

    initial begin
        void'($urandom(32'hfc65));
        rst_n      = 1'b0;
        imem_data  = NOP_INSTR;
        wb_rdata   = '0;
        wb_ack     = 1'b0;
        reset_errs = 0;
        seq_errs   = 0;
        stall_errs = 0;
        mem_errs   = 0;
        acc_count  = 0;
        marker_seen = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            dmem[i]    = init_word(32'(i) << 2);
            mdl_mem[i] = init_word(32'(i) << 2);
        end
        build_program();
        run_model();

        // bus idle and fetch at the reset pc through three reset cycles and at release
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            #1;
            if (c == 2) begin
                rst_n = 1'b1;
            end
            if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
                reset_errs++;
                $display("bus request active during or right after reset");
            end
            if (imem_addr !== RESET_PC[IMEM_AW+1:2]) begin
                reset_errs++;
                $display("MISMATCH imem_addr: got %h expected %h",
                         imem_addr, RESET_PC[IMEM_AW+1:2]);
            end
        end
        $display("test reset: %0d errors", reset_errs);

        cycles = 0;
        while (!marker_seen && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (!marker_seen) begin
            $display("timeout: marker store not seen within 5000 cycles");
            $display("Done: errors found");
            $finish;
        end else begin
            if (acc_count != exp_adr.size()) begin
                seq_errs++;
                $display("access count %0d differs from expected %0d",
                         acc_count, exp_adr.size());
            end
            $display("test access sequence: %0d accesses, %0d errors", acc_count, seq_errs);
            $display("test back-pressure: %0d errors", stall_errs);
            for (int i = 0; i < 1024; i++) begin
                if (dmem[i] !== mdl_mem[i]) begin
                    mem_errs++;
                    $display("MISMATCH dmem[%h]: got %h expected %h", i, dmem[i], mdl_mem[i]);
                end
            end
            $display("test final memory: %0d errors", mem_errs);
            total = reset_errs + seq_errs + stall_errs + mem_errs;
            $display("4 tests, %0d cycles, errors: reset %0d sequence %0d stall %0d memory %0d",
                     cycles, reset_errs, seq_errs, stall_errs, mem_errs);
            if (total == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

/* source/core_cfg_pkg.sv */
package core_cfg_pkg;

    // machine word width
    localparam int XLEN = 32;

    // data, pc and instruction words
    typedef logic [XLEN-1:0] word_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // instruction port takes a word index, not a byte address
    localparam int IMEM_AW = 10;

    typedef logic [IMEM_AW-1:0] imem_addr_t;

endpackage

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hold,
    input  logic                   ex_valid,
    input  core_cfg_pkg::word_t    ex_pc,
    input  core_cfg_pkg::word_t    ex_instr,
    input  core_cfg_pkg::word_t    ex_rs1_val,
    input  core_cfg_pkg::word_t    ex_rs2_val,
    input  core_cfg_pkg::word_t    ex_imm,
    input  logic                   wb_en,
    input  core_cfg_pkg::reg_idx_t wb_rd,
    input  core_cfg_pkg::word_t    wb_value,
    output logic                   redirect,
    output core_cfg_pkg::word_t    redirect_pc,
    output logic                   mem_valid,
    output core_cfg_pkg::word_t    mem_instr,
    output core_cfg_pkg::word_t    mem_result,
    output core_cfg_pkg::word_t    mem_store_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    funct3_t    funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_b;
    word_t      alu_out;
    word_t      result;
    logic [4:0] shamt;
    logic       is_alt;
    logic       eq;
    logic       lt;
    logic       ltu;
    logic       taken;

    assign opcode = ex_instr[6:0];
    assign funct3 = ex_instr[14:12];
    assign rs1    = ex_instr[19:15];
    assign rs2    = ex_instr[24:20];

    // producer one ahead is in writeback now, its value beats the decode read
    assign op_a = (wb_en && (wb_rd != '0) && (wb_rd == rs1)) ? wb_value : ex_rs1_val;
    assign op_b = (wb_en && (wb_rd != '0) && (wb_rd == rs2)) ? wb_value : ex_rs2_val;

    // reg-reg uses rs2, everything else the immediate
    assign alu_b  = (opcode == OPC_OP) ? op_b : ex_imm;
    assign is_alt = (ex_instr[31:25] == F7_ALT);
    assign shamt  = alu_b[4:0];

    always_comb begin
        case (funct3)
            // sub only for reg-reg, addi has no alt form
            F3_ADD:  alu_out = (opcode == OPC_OP && is_alt) ? op_a - alu_b : op_a + alu_b;
            F3_SLL:  alu_out = op_a << shamt;
            F3_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            F3_SLTU: alu_out = {31'd0, op_a < alu_b};
            F3_XOR:  alu_out = op_a ^ alu_b;
            F3_SR:   alu_out = is_alt ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
            F3_OR:   alu_out = op_a | alu_b;
            F3_AND:  alu_out = op_a & alu_b;
        endcase
    end

    // jal links pc+4, memory ops carry the effective address
    always_comb begin
        case (opcode)
            OPC_LUI:             result = ex_imm;
            OPC_JAL:             result = ex_pc + 32'd4;
            OPC_LOAD, OPC_STORE: result = op_a + ex_imm;
            default:             result = alu_out;
        endcase
    end

    // branch compare on forwarded operands
    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // frozen instruction waits, fires once hold drops
    assign redirect = ex_valid && !hold &&
                      (((opcode == OPC_BRANCH) && taken) || (opcode == OPC_JAL));
    // b and j immediates are both pc relative
    assign redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (!hold) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_instr      <= ex_instr;
            mem_result     <= result;
            mem_store_data <= op_b;
        end
    end

    // no redirect while stalled, and the slot it kills reaches execute dead
    a_redirect_kills: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> !hold ##1 !ex_valid);

endmodule

/* source/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     hold,
    input  logic                     redirect,
    input  core_cfg_pkg::word_t      redirect_pc,
    output core_cfg_pkg::imem_addr_t imem_addr,
    input  core_cfg_pkg::word_t      imem_data,
    input  logic                     wb_en,
    input  core_cfg_pkg::reg_idx_t   wb_rd,
    input  core_cfg_pkg::word_t      wb_value,
    output logic                     ex_valid,
    output core_cfg_pkg::word_t      ex_pc,
    output core_cfg_pkg::word_t      ex_instr,
    output core_cfg_pkg::word_t      ex_rs1_val,
    output core_cfg_pkg::word_t      ex_rs2_val,
    output core_cfg_pkg::word_t      ex_imm
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // address of the word now on imem_data
    word_t pc;
    // imem_data is a real fetch, low until the first post-reset edge
    logic  if_valid;
    word_t next_pc;
    logic  kill;
    word_t instr;
    word_t imm;
    word_t rs1_val;
    word_t rs2_val;

    // stall or not yet running re-reads the same word
    always_comb begin
        if (hold || !if_valid) begin
            next_pc = pc;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // next pc goes out now, so its word is back next cycle
    assign imem_addr = next_pc[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            if_valid <= 1'b1;
        end
    end

    // wrong-path word behind a taken branch or jal
    assign kill  = redirect || !if_valid;
    assign instr = kill ? NOP_INSTR : imem_data;

    // immediate by format
    always_comb begin
        case (instr[6:0])
            OPC_OP_IMM, OPC_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
            OPC_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            OPC_LUI:    imm = {instr[31:12], 12'd0};
            default:    imm = '0;
        endcase
    end

    // writeback bypass lives inside the register file
    reg_file u_reg_file (
        .clk (clk),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd1 (rs1_val),
        .rd2 (rs2_val),
        .we  (wb_en),
        .wa  (wb_rd),
        .wd  (wb_value)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= !kill;
        end
    end

    // decode-to-execute payload, frozen by hold
    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_pc      <= pc;
            ex_instr   <= instr;
            ex_rs1_val <= rs1_val;
            ex_rs2_val <= rs2_val;
            ex_imm     <= imm;
        end
    end

endmodule

/* source/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_valid,
    input  core_cfg_pkg::word_t    mem_instr,
    input  core_cfg_pkg::word_t    mem_result,
    input  core_cfg_pkg::word_t    mem_store_data,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output logic                   wb_we,
    output core_cfg_pkg::word_t    wb_adr,
    output core_cfg_pkg::word_t    wb_wdata,
    input  core_cfg_pkg::word_t    wb_rdata,
    input  logic                   wb_ack,
    output logic                   hold,
    output logic                   wb_en,
    output core_cfg_pkg::reg_idx_t wb_rd,
    output core_cfg_pkg::word_t    wb_value
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic       is_load;
    logic       is_store;
    logic       mem_ls;
    logic       writes_rd;
    // bus cycle outstanding
    logic       busy;
    logic       ack_seen;

    assign opcode   = mem_instr[6:0];
    assign is_load  = mem_valid && (opcode == OPC_LOAD);
    assign is_store = mem_valid && (opcode == OPC_STORE);
    assign mem_ls   = is_load || is_store;

    // request rises the cycle after the access arrives, falls on the ack edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (busy && wb_ack) begin
            busy <= 1'b0;
        end else if (!busy && mem_ls) begin
            busy <= 1'b1;
        end
    end

    assign ack_seen = busy && wb_ack;

    // stages 1 and 2 wait until the slave answers
    assign hold = mem_ls && !ack_seen;

    // address and data come from stage registers that hold freezes
    assign wb_cyc   = busy;
    assign wb_stb   = busy;
    assign wb_we    = busy && is_store;
    assign wb_adr   = {mem_result[31:2], 2'b00};
    assign wb_wdata = mem_store_data;

    // stores and branches leave rd alone
    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL, OPC_LOAD: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // load data only counts in its ack cycle
    assign wb_en    = mem_valid && writes_rd && (!is_load || ack_seen);
    assign wb_rd    = mem_instr[11:7];
    assign wb_value = is_load ? wb_rdata : mem_result;

    // pending request stays on the bus unchanged until acked
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) &&
                              $stable(wb_we) && $stable(wb_wdata));

    // an outstanding access keeps its load or store in stage 3
    a_access_held: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> mem_ls);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  core_cfg_pkg::reg_idx_t rs1,
    input  core_cfg_pkg::reg_idx_t rs2,
    output core_cfg_pkg::word_t    rd1,
    output core_cfg_pkg::word_t    rd2,
    input  logic                   we,
    input  core_cfg_pkg::reg_idx_t wa,
    input  core_cfg_pkg::word_t    wd
);
    import core_cfg_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    // x0 reads zero, a same-cycle write shows through
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we && (wa == idx)) begin
            val = wd;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rd1 = read_port(rs1);
        rd2 = read_port(rs2);
    end

    // writes to x0 dropped
    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

/* source/rv3_core.sv */
`timescale 1ns/1ps

module rv3_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output core_cfg_pkg::imem_addr_t imem_addr,
    input  core_cfg_pkg::word_t      imem_data,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output core_cfg_pkg::word_t      wb_adr,
    output core_cfg_pkg::word_t      wb_wdata,
    input  core_cfg_pkg::word_t      wb_rdata,
    input  logic                     wb_ack
);
    // stall and control flow
    logic                   hold;
    logic                   redirect;
    core_cfg_pkg::word_t    redirect_pc;
    // writeback, also the forwarding source
    logic                   wb_en;
    core_cfg_pkg::reg_idx_t wb_rd;
    core_cfg_pkg::word_t    wb_value;
    // decode to execute
    logic                   ex_valid;
    core_cfg_pkg::word_t    ex_pc;
    core_cfg_pkg::word_t    ex_instr;
    core_cfg_pkg::word_t    ex_rs1_val;
    core_cfg_pkg::word_t    ex_rs2_val;
    core_cfg_pkg::word_t    ex_imm;
    // execute to memory
    logic                   mem_valid;
    core_cfg_pkg::word_t    mem_instr;
    core_cfg_pkg::word_t    mem_result;
    core_cfg_pkg::word_t    mem_store_data;

    fetch_decode u_fetch_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_instr    (ex_instr),
        .ex_rs1_val  (ex_rs1_val),
        .ex_rs2_val  (ex_rs2_val),
        .ex_imm      (ex_imm)
    );

    execute_stage u_execute_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_instr       (ex_instr),
        .ex_rs1_val     (ex_rs1_val),
        .ex_rs2_val     (ex_rs2_val),
        .ex_imm         (ex_imm),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_value       (wb_value),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mem_valid      (mem_valid),
        .mem_instr      (mem_instr),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_instr      (mem_instr),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_wdata       (wb_wdata),
        .wb_rdata       (wb_rdata),
        .wb_ack         (wb_ack),
        .hold           (hold),
        .wb_en          (wb_en),
        .wb_rd          (wb_rd),
        .wb_value       (wb_value)
    );

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes used by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef logic [2:0] funct3_t;

    // alu funct3, same codes for reg-reg and reg-imm forms
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    // srl and sra share one code, funct7 picks
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // funct7 value for sub, sra and srai
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

/* vlog.f */
+incdir+sim
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/reg_file.sv
source/fetch_decode.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv3_core.sv
sim/tb_rv3_core.sv
